/* test/wb_tests.txt */
# I pc we reg data flags | N | E trace_pc ex ecode rf_we redirect_valid redirect_pc
# R reg value | W csr mask data | C csr value  (hex; flags = ale adef ine sys brk int ertn)
C 000 00000008
C 00c 1c000000
W 00c ffffffff 1c008abc
C 00c 1c008a80
W 00c 0000ff00 ffffffff
C 00c 1c00ff80
W 000 00000007 00000007
C 000 0000000f
W 005 ffffffff ffffffff
C 005 00000003
W 006 ffffffff 12345677
C 006 12345674
W 001 00000004 ffffffff
C 001 00000004
C 007 00000000
I 1c000000 1 01 11111111 00
N
E 1c000000 0 00 1 0 00000000
R 01 11111111
I 1c000004 1 1f a5a5a5a5 00
I 1c000008 1 00 deadbeef 00
E 1c000004 0 00 1 0 00000000
N
E 1c000008 0 00 1 0 00000000
R 1f a5a5a5a5
R 00 00000000
I 1c000100 1 02 cafef00d 54
N
E 1c000100 1 09 0 1 1c00ff80
C 005 00090003
C 006 1c000100
C 001 00000007
C 000 00000008
R 02 00000000
I 1c000110 1 06 00000006 28
N
E 1c000110 1 08 0 1 1c00ff80
I 1c000120 1 06 00000006 0c
N
E 1c000120 1 0b 0 1 1c00ff80
I 1c000130 1 06 00000006 14
N
E 1c000130 1 0c 0 1 1c00ff80
I 1c000140 1 06 00000006 10
N
E 1c000140 1 0d 0 1 1c00ff80
I 1c000200 1 03 12121212 7e
I 1c000204 1 04 34343434 00
E 1c000200 1 00 0 1 1c00ff80
N
E 1c000200 0 00 0 0 00000000
R 03 00000000
R 04 00000000
R 06 00000000
C 005 00000003
C 006 1c000200
W 001 ffffffff 00000006
C 001 00000006
I 1c000300 1 05 55aa55aa 01
N
E 1c000300 0 00 1 1 1c000200
C 000 0000000e
R 05 55aa55aa

/* sources.f */
+incdir+logic
logic/wb_pkg.sv
logic/reg_file.sv
logic/wb_stage.sv
logic/csr_file.sv
logic/wb_subsystem.sv
test/wb_tb.sv

/* run.sh */
#!/bin/sh
# build and run the writeback subsystem testbench with verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "could not change to the project root"
    exit 1
fi

verilator --binary --timing --assert -j 0 --top-module wb_tb -f sources.f -o wb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# run from the project root so the data file path resolves
./obj_dir/wb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi
exit 0

/* test/wb_tb.sv */
`timescale 1ns/1ps

module wb_tb import wb_pkg::*; ();

    localparam string TEST_FILE    = "test/wb_tests.txt";
    localparam int    IDLE_TIMEOUT = 20;    // cycles

    logic        clk;
    logic        resetn;
    logic        ms_valid;
    logic [31:0] ms_pc;
    logic        ms_rf_we;
    logic [4:0]  ms_rf_waddr;
    logic [31:0] ms_rf_wdata;
    except_bus_u ms_except;
    logic [13:0] csr_num;
    logic        csr_we;
    logic [31:0] csr_wmask;
    logic [31:0] csr_wdata;
    logic [31:0] csr_rdata;
    logic [4:0]  raddr1;
    logic [31:0] rdata1;
    logic [4:0]  raddr2;
    logic [31:0] rdata2;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;
    logic        wb_ex;
    ecode_t      wb_ecode;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    int fd;

    // register write of each issued record, by pc
    logic [4:0]  sent_waddr [logic [31:0]];
    logic [31:0] sent_wdata [logic [31:0]];

    wb_subsystem i_wb_subsystem (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t ns: %s got %08h expected %08h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_ecode(input ecode_t got, input ecode_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t ns: %s got %02h expected %02h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
                                $time, what, got, exp));
        end
    endtask

    // each cycle starts at the falling edge with an idle record of random data
    task automatic start_cycle();
        @(negedge clk);
        ms_valid    = 1'b0;
        ms_rf_we    = 1'b0;
        ms_rf_wdata = $urandom;
        ms_except   = '0;
        csr_we      = 1'b0;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (wb_ex || redirect_valid || (debug_wb_rf_we != 4'h0)) begin
            if (cycles == IDLE_TIMEOUT) begin
                abort_run("timeout: writeback stage did not go idle after reset");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic issue_record(input logic [31:0] pc, input logic we, input logic [4:0] addr,
                                input logic [31:0] data, input logic [6:0] flags);
        start_cycle();
        ms_valid      = 1'b1;
        ms_pc         = pc;
        ms_rf_we      = we;
        ms_rf_waddr   = addr;
        ms_rf_wdata   = data;
        ms_except.raw = flags;
        sent_waddr[pc] = addr;
        sent_wdata[pc] = data;
        #3;     // sample 1 ns before the rising edge
    endtask

    task automatic idle_cycle();
        start_cycle();
        #3;
    endtask

    // outputs of the record held in the current cycle
    task automatic check_held(input logic [31:0] pc, input logic ex, input ecode_t code,
                              input logic we, input logic rv, input logic [31:0] rpc);
        check_word(debug_wb_pc, pc, "trace pc");
        check_bit(wb_ex, ex, "wb_ex");
        if (ex) begin
            check_ecode(wb_ecode, code, "wb_ecode");
        end
        check_word({28'h0, debug_wb_rf_we}, {28'h0, {4{we}}}, "trace write enable");
        if (we) begin
            if (!sent_waddr.exists(pc)) begin
                abort_run($sformatf("expected write for pc %08h, which was never issued", pc));
            end
            check_word({27'h0, debug_wb_rf_wnum}, {27'h0, sent_waddr[pc]},
                       "trace write number");
            check_word(debug_wb_rf_wdata, sent_wdata[pc], "trace write data");
        end
        check_bit(redirect_valid, rv, "redirect_valid");
        if (rv) begin
            check_word(redirect_pc, rpc, "redirect_pc");
        end
    endtask

    task automatic read_reg(input logic [4:0] addr, input logic [31:0] exp);
        start_cycle();
        raddr1 = addr;
        raddr2 = addr;
        #3;
        check_word(rdata1, exp, $sformatf("r%0d on read port 1", addr));
        check_word(rdata2, exp, $sformatf("r%0d on read port 2", addr));
    endtask

    task automatic write_csr(input logic [13:0] num, input logic [31:0] mask,
                             input logic [31:0] data);
        start_cycle();
        csr_num   = num;
        csr_we    = 1'b1;
        csr_wmask = mask;
        csr_wdata = data;
        #3;
    endtask

    task automatic read_csr(input logic [13:0] num, input logic [31:0] exp);
        start_cycle();
        csr_num = num;
        #3;
        check_word(csr_rdata, exp, $sformatf("csr %03h", num));
    endtask

    task automatic bad_line(input logic [7:0] cmd);
        abort_run($sformatf("malformed '%c' command in %s", cmd, TEST_FILE));
    endtask

    task automatic run_commands();
        int          code;
        logic [7:0]  cmd;
        string       rest;
        logic [31:0] a, b, c, d, e, f;
        bit          done;
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1) begin
                done = 1'b1;    // end of file
            end else begin
                case (cmd)
                    "#": code = $fgets(rest, fd);
                    "I": begin
                        if ($fscanf(fd, "%h %h %h %h %h", a, b, c, d, e) != 5) bad_line(cmd);
                        issue_record(a, b[0], c[4:0], d, e[6:0]);
                    end
                    "N": idle_cycle();
                    "E": begin
                        if ($fscanf(fd, "%h %h %h %h %h %h", a, b, c, d, e, f) != 6) begin
                            bad_line(cmd);
                        end
                        check_held(a, b[0], c[5:0], d[0], e[0], f);
                    end
                    "R": begin
                        if ($fscanf(fd, "%h %h", a, b) != 2) bad_line(cmd);
                        read_reg(a[4:0], b);
                    end
                    "W": begin
                        if ($fscanf(fd, "%h %h %h", a, b, c) != 3) bad_line(cmd);
                        write_csr(a[13:0], b, c);
                    end
                    "C": begin
                        if ($fscanf(fd, "%h %h", a, b) != 2) bad_line(cmd);
                        read_csr(a[13:0], b);
                    end
                    default: abort_run($sformatf("unknown command '%c' in %s", cmd, TEST_FILE));
                endcase
            end
        end
    endtask

    initial begin
        void'($urandom(32'h0615_3ccf));
        resetn      = 1'b0;
        ms_valid    = 1'b0;
        ms_pc       = 32'h0;
        ms_rf_we    = 1'b0;
        ms_rf_waddr = 5'd0;
        ms_rf_wdata = 32'h0;
        ms_except   = '0;
        csr_num     = 14'h0;
        csr_we      = 1'b0;
        csr_wmask   = 32'h0;
        csr_wdata   = 32'h0;
        raddr1      = 5'd0;
        raddr2      = 5'd0;

        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        wait_idle();

        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            abort_run($sformatf("could not open the test data file %s", TEST_FILE));
        end
        run_commands();
        $fclose(fd);

        $display("all tests passed");
        $finish;
    end

endmodule

/* logic/wb_subsystem.sv */
`timescale 1ns/1ps

module wb_subsystem import wb_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    // memory stage record
    input  logic        ms_valid,
    input  logic [31:0] ms_pc,
    input  logic        ms_rf_we,
    input  logic [4:0]  ms_rf_waddr,
    input  logic [31:0] ms_rf_wdata,
    input  except_bus_u ms_except,
    // csr software port
    input  logic [13:0] csr_num,
    input  logic        csr_we,
    input  logic [31:0] csr_wmask,
    input  logic [31:0] csr_wdata,
    output logic [31:0] csr_rdata,
    // register read ports for decode
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    // debug trace
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata,
    // exception status and redirect
    output logic        wb_ex,
    output ecode_t      wb_ecode,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);

    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;
    logic [31:0] wb_pc;
    logic        ertn_flush;

    wb_stage i_wb_stage (
        .clk               (clk),
        .resetn            (resetn),
        .ms_valid          (ms_valid),
        .ms_pc             (ms_pc),
        .ms_rf_we          (ms_rf_we),
        .ms_rf_waddr       (ms_rf_waddr),
        .ms_rf_wdata       (ms_rf_wdata),
        .ms_except         (ms_except),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .wb_ex             (wb_ex),
        .wb_ecode          (wb_ecode),
        .wb_pc             (wb_pc),
        .ertn_flush        (ertn_flush),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    csr_file i_csr_file (
        .clk            (clk),
        .resetn         (resetn),
        .wb_ex          (wb_ex),
        .wb_ecode       (wb_ecode),
        .wb_pc          (wb_pc),
        .ertn_flush     (ertn_flush),
        .csr_num        (csr_num),
        .csr_we         (csr_we),
        .csr_wmask      (csr_wmask),
        .csr_wdata      (csr_wdata),
        .csr_rdata      (csr_rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    reg_file i_reg_file (
        .clk    (clk),
        .resetn (resetn),
        .raddr1 (raddr1),
        .rdata1 (rdata1),
        .raddr2 (raddr2),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

endmodule

/* logic/csr_file.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module csr_file import wb_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    // hardware update from writeback
    input  logic        wb_ex,
    input  ecode_t      wb_ecode,
    input  logic [31:0] wb_pc,
    input  logic        ertn_flush,
    // software access
    input  logic [13:0] csr_num,
    input  logic        csr_we,
    input  logic [31:0] csr_wmask,
    input  logic [31:0] csr_wdata,
    output logic [31:0] csr_rdata,
    // front end redirect
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);

    localparam logic [31:0] CRMD_RST   = `CRMD_RESET;
    localparam logic [31:0] EENTRY_RST = `EENTRY_RESET;

    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic        crmd_da;
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    logic [1:0]  estat_is;      // software interrupt bits
    ecode_t      estat_ecode;
    logic [31:0] era;
    logic [25:0] eentry_va;     // bits 31:6

    logic [31:0] crmd_word, prmd_word, estat_word, eentry_word;
    logic [31:0] crmd_sw, prmd_sw, estat_sw, era_sw, eentry_sw;
    logic        sw_crmd, sw_prmd, sw_estat, sw_era, sw_eentry;

    // keep unmasked bits, take masked bits from csr_wdata
    function automatic logic [31:0] sw_merge(input logic [31:0] old_v,
                                             input logic [31:0] fld);
        logic [31:0] m;
        m = csr_wmask & fld;
        return (old_v & ~m) | (csr_wdata & m);
    endfunction

    assign crmd_word   = {28'h0, crmd_da, crmd_ie, crmd_plv};
    assign prmd_word   = {29'h0, prmd_pie, prmd_pplv};
    assign estat_word  = {1'b0, 9'h000, estat_ecode, 14'h0000, estat_is}; // esubcode zero
    assign eentry_word = {eentry_va, 6'h00};

    assign sw_crmd   = csr_we && (csr_num == `CSR_CRMD);
    assign sw_prmd   = csr_we && (csr_num == `CSR_PRMD);
    assign sw_estat  = csr_we && (csr_num == `CSR_ESTAT);
    assign sw_era    = csr_we && (csr_num == `CSR_ERA);
    assign sw_eentry = csr_we && (csr_num == `CSR_EENTRY);

    assign crmd_sw   = sw_merge(crmd_word, `CRMD_WMASK);
    assign prmd_sw   = sw_merge(prmd_word, `PRMD_WMASK);
    assign estat_sw  = sw_merge(estat_word, `ESTAT_WMASK);
    assign era_sw    = sw_merge(era, `ERA_WMASK);
    assign eentry_sw = sw_merge(eentry_word, `EENTRY_WMASK);

    // crmd, hardware update beats software
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= CRMD_RST[1:0];
            crmd_ie  <= CRMD_RST[2];
            crmd_da  <= CRMD_RST[3];
        end else if (wb_ex) begin
            crmd_plv <= 2'b00;          // enter kernel
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (sw_crmd) begin
            crmd_plv <= crmd_sw[1:0];
            crmd_ie  <= crmd_sw[2];
            crmd_da  <= crmd_sw[3];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd_pplv <= 2'b00;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            prmd_pplv <= crmd_plv;      // save pre-exception state
            prmd_pie  <= crmd_ie;
        end else if (sw_prmd) begin
            prmd_pplv <= prmd_sw[1:0];
            prmd_pie  <= prmd_sw[2];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_is    <= 2'b00;
            estat_ecode <= 6'h00;
        end else if (wb_ex) begin
            estat_ecode <= wb_ecode;
        end else if (sw_estat) begin
            estat_is <= estat_sw[1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            era <= 32'h0;
        end else if (wb_ex) begin
            era <= wb_pc;
        end else if (sw_era) begin
            era <= era_sw;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            eentry_va <= EENTRY_RST[31:6];
        end else if (sw_eentry) begin
            eentry_va <= eentry_sw[31:6];
        end
    end

    always_comb begin
        case (csr_num)
            `CSR_CRMD:   csr_rdata = crmd_word;
            `CSR_PRMD:   csr_rdata = prmd_word;
            `CSR_ESTAT:  csr_rdata = estat_word;
            `CSR_ERA:    csr_rdata = era;
            `CSR_EENTRY: csr_rdata = eentry_word;
            default:     csr_rdata = 32'h0;   // unimplemented
        endcase
    end

    assign redirect_valid = wb_ex | ertn_flush;
    assign redirect_pc    = wb_ex ? eentry_word : era;

    // pc comes from upstream, so check alignment of the target here
    a_redirect_aligned: assert property (@(posedge clk) disable iff (!resetn)
        redirect_valid |-> (redirect_pc[1:0] == 2'b00))
        else $error("redirect target not word aligned");

endmodule

/* logic/wb_stage.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module wb_stage import wb_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    // record from memory stage
    input  logic        ms_valid,
    input  logic [31:0] ms_pc,
    input  logic        ms_rf_we,
    input  logic [4:0]  ms_rf_waddr,
    input  logic [31:0] ms_rf_wdata,
    input  except_bus_u ms_except,
    // register file write
    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    // to csr block
    output logic        wb_ex,
    output ecode_t      wb_ecode,
    output logic [31:0] wb_pc,
    output logic        ertn_flush,
    // debug trace
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    logic        ws_valid;
    logic [31:0] ws_pc;
    logic        ws_rf_we;
    logic [4:0]  ws_rf_waddr;
    logic [31:0] ws_rf_wdata;
    except_bus_u ws_except;
    logic        flush;
    logic        flagged_ex;    // any exception by named flag

    assign flush = wb_ex | ertn_flush;

    // a flush drops the record offered in its cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ws_valid <= 1'b0;
        end else if (flush) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_valid && !flush) begin
            ws_pc       <= ms_pc;
            ws_rf_we    <= ms_rf_we;
            ws_rf_waddr <= ms_rf_waddr;
            ws_rf_wdata <= ms_rf_wdata;
            ws_except   <= ms_except;
        end
    end

    // bit 0 is ertn and the rest are real exceptions
    assign wb_ex      = ws_valid & (|ws_except.raw[6:1]);
    assign ertn_flush = ws_valid & ws_except.flags.ertn & ~wb_ex;

    // priority int > adef > ale > syscall > brk > ine
    always_comb begin
        if (ws_except.flags.intr) begin
            wb_ecode = `ECODE_INT;
        end else if (ws_except.flags.adef) begin
            wb_ecode = `ECODE_ADE;
        end else if (ws_except.flags.ale) begin
            wb_ecode = `ECODE_ALE;
        end else if (ws_except.flags.syscall) begin
            wb_ecode = `ECODE_SYS;
        end else if (ws_except.flags.brk) begin
            wb_ecode = `ECODE_BRK;
        end else if (ws_except.flags.ine) begin
            wb_ecode = `ECODE_INE;
        end else begin
            wb_ecode = 6'h00;
        end
    end

    assign wb_pc = ws_pc;

    // ertn still writes back if enabled
    assign rf_we    = ws_valid & ws_rf_we & ~wb_ex;
    assign rf_waddr = ws_rf_waddr;
    assign rf_wdata = ws_rf_wdata;

    assign debug_wb_pc       = ws_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = ws_rf_waddr;
    assign debug_wb_rf_wdata = ws_rf_wdata;

    // named view of the flag word, against the raw reduction above
    assign flagged_ex = ws_except.flags.intr | ws_except.flags.adef |
                        ws_except.flags.ale | ws_except.flags.syscall |
                        ws_except.flags.brk | ws_except.flags.ine;

    a_ex_ertn_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        (ws_valid && flagged_ex) |-> (wb_ex && !ertn_flush))
        else $error("excepting record did not retire as an exception alone");

    a_no_write_on_ex: assert property (@(posedge clk) disable iff (!resetn)
        (ws_valid && flagged_ex) |-> !rf_we)
        else $error("register write from an excepting record");

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module reg_file (
    input  logic        clk,
    input  logic        resetn,
    // read ports, combinational
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    // write port
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [`RF_NUM];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `RF_NUM; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (we && (waddr != 5'd0)) begin   // r0 never written
            regs[waddr] <= wdata;
        end
    end

    // no bypass, a write shows up after the edge
    assign rdata1 = (raddr1 == 5'd0) ? 32'h0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'h0 : regs[raddr2];

endmodule

/* logic/wb_pkg.sv */
package wb_pkg;

    // exception code as written into estat
    typedef logic [5:0] ecode_t;

    // per-record exception and ertn flags, msb first
    typedef struct packed {
        logic ale;
        logic adef;
        logic ine;
        logic syscall;
        logic brk;
        logic intr;
        logic ertn;     // not an exception, return request
    } except_flags_t;

    // same seven bits seen as named flags or as one word
    typedef union packed {
        except_flags_t flags;
        logic [6:0]    raw;
    } except_bus_u;

endpackage

/* logic/wb_consts.svh */
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// exception codes for estat.ecode
`define ECODE_INT    6'h00
`define ECODE_ADE    6'h08   // fetch address error
`define ECODE_ALE    6'h09   // misaligned load/store
`define ECODE_SYS    6'h0B
`define ECODE_BRK    6'h0C
`define ECODE_INE    6'h0D   // instruction not exist

// csr numbers decoded by csr_file
`define CSR_CRMD     14'h000
`define CSR_PRMD     14'h001
`define CSR_ESTAT    14'h005
`define CSR_ERA      14'h006
`define CSR_EENTRY   14'h00C

// reset values
`define CRMD_RESET   32'h0000_0008   // da=1, plv=0, ie=0
`define EENTRY_RESET 32'h1C00_0000

// implemented bits, software write is limited to these
`define CRMD_WMASK   32'h0000_000F   // da, ie, plv
`define PRMD_WMASK   32'h0000_0007   // pie, pplv
`define ESTAT_WMASK  32'h0000_0003   // software interrupt bits
`define ERA_WMASK    32'hFFFF_FFFC   // word aligned return address
`define EENTRY_WMASK 32'hFFFF_FFC0   // 64-byte aligned entry

// general register file
`define RF_NUM       32

`endif
